//--- filelist.f
hdl/rv_pkg.sv
hdl/wb_if.sv
hdl/ctrl_if.sv
hdl/control.sv
hdl/alu.sv
hdl/imm_gen.sv
hdl/reg_file.sv
hdl/bus_sequencer.sv
hdl/rv_top.sv
sim/tb_clk_gen.sv
sim/tb_rv_top.sv

//--- sim/tb_rv_top.sv
`timescale 1ns/100ps

module tb_rv_top;

    localparam rv_pkg::addr_t RESET_PC = 32'h0000_0040;
    localparam rv_pkg::addr_t RES_BASE = 32'h0000_0200;   // Result area base held in x10
    localparam rv_pkg::word_t A_VAL    = 32'h80F0_F000 + 32'h0000_00F5;  // LUI then ADDI
    localparam rv_pkg::word_t B_VAL    = 32'hFFFF_FAAA;    // ADDI -1366 with shamt 10

    logic          clk;
    logic          rst;
    logic          wb_cyc;
    logic          wb_stb;
    logic          wb_we;
    rv_pkg::addr_t wb_adr;
    rv_pkg::word_t wb_dat_w;
    rv_pkg::word_t wb_dat_r;
    logic          wb_ack;

    rv_pkg::word_t mem [0:255];                        // 1 KiB bus memory
    rv_pkg::addr_t exp_adr [$];                        // Expected stores in program order
    rv_pkg::word_t exp_dat [$];
    rv_pkg::addr_t jump_from [0:1];                    // Taken branch and JAL
    rv_pkg::addr_t jump_to [0:1];
    rv_pkg::addr_t pc_w;                               // Program build pointer
    logic [11:0]   res_off;
    rv_pkg::addr_t end_pc;                             // Final self loop
    rv_pkg::addr_t last_fetch;
    int            st_idx;
    int            end_hits;
    int            cnt;
    logic          fetch_seen;
    integer        seed;
    logic [31:0]   rnd;
    logic [1:0]    delay;                              // Cycles left before ack
    logic          rst_edge;                           // rst at the last rising edge
    logic          rst_edge_d;
    logic          prev_stb;
    logic          prev_ack;
    logic          prev_we;
    rv_pkg::addr_t prev_adr;
    rv_pkg::word_t prev_dat;

    tb_clk_gen tb_clk_gen_i (
        .clk_o (clk),
        .rst_o (rst)
    );

    rv_top #(
        .RESET_PC (RESET_PC)
    ) rv_top_i (
        .clk_i    (clk),
        .rst_i    (rst),
        .wb_cyc_o (wb_cyc),
        .wb_stb_o (wb_stb),
        .wb_we_o  (wb_we),
        .wb_adr_o (wb_adr),
        .wb_dat_o (wb_dat_w),
        .wb_dat_i (wb_dat_r),
        .wb_ack_i (wb_ack)
    );

    // ====================
    // Error reporting
    // ====================
    task automatic value_mismatch(input string name, input rv_pkg::word_t exp,
                                  input rv_pkg::word_t act);
        $display("ERR %0t %s expected %h actual %h", $time, name, exp, act);
        $display("sim failed");
        $fatal(1);
    endtask

    task automatic abort_run(input string why);
        $display("sim failed");
        $display("%s", why);
        $fatal(1);
    endtask

    // ====================
    // RV32I encoders
    // ====================
    function automatic rv_pkg::word_t r_insn(input logic [6:0] f7, input rv_pkg::reg_idx_t rs2,
                                             input rv_pkg::reg_idx_t rs1, input logic [2:0] f3,
                                             input rv_pkg::reg_idx_t rd);
        return {f7, rs2, rs1, f3, rd, rv_pkg::OP_R};
    endfunction

    function automatic rv_pkg::word_t i_insn(input logic [11:0] imm, input rv_pkg::reg_idx_t rs1,
                                             input logic [2:0] f3, input rv_pkg::reg_idx_t rd,
                                             input rv_pkg::opcode_t op);
        return {imm, rs1, f3, rd, op};                 // Also LW
    endfunction

    function automatic rv_pkg::word_t s_insn(input logic [11:0] imm, input rv_pkg::reg_idx_t rs2,
                                             input rv_pkg::reg_idx_t rs1);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], rv_pkg::OP_STORE};
    endfunction

    function automatic rv_pkg::word_t b_insn(input logic [12:0] imm, input rv_pkg::reg_idx_t rs2,
                                             input rv_pkg::reg_idx_t rs1, input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], rv_pkg::OP_BRANCH};
    endfunction

    function automatic rv_pkg::word_t j_insn(input logic [20:0] imm, input rv_pkg::reg_idx_t rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, rv_pkg::OP_JAL};
    endfunction

    function automatic rv_pkg::word_t u_insn(input logic [19:0] imm, input rv_pkg::reg_idx_t rd);
        return {imm, rd, rv_pkg::OP_LUI};
    endfunction

    // ====================
    // Program image
    // ====================
    task automatic emit(input rv_pkg::word_t insn);
        mem[pc_w[9:2]] = insn;
        pc_w = pc_w + 32'd4;
    endtask

    task automatic expect_store(input rv_pkg::addr_t adr, input rv_pkg::word_t dat);
        exp_adr.push_back(adr);
        exp_dat.push_back(dat);
    endtask

    // SW rs2 to the next result slot
    task automatic store_result(input rv_pkg::reg_idx_t rs2, input rv_pkg::word_t dat);
        emit(s_insn(res_off, rs2, 5'd10));
        expect_store(RES_BASE + res_off, dat);
        res_off = res_off + 12'd4;
    endtask

    task automatic load_program;
        rv_pkg::addr_t jal_pc;
        for (int i = 0; i < 256; i++) begin
            mem[i] = {16'hc0de, 8'h00, 8'(i)};         // Never executed
        end
        pc_w    = RESET_PC;
        res_off = '0;
        emit(u_insn(20'h80F0F, 5'd1));
        emit(i_insn(12'h0F5, 5'd1, 3'b000, 5'd1, rv_pkg::OP_I));
        emit(i_insn(12'hAAA, 5'd0, 3'b000, 5'd2, rv_pkg::OP_I));
        emit(i_insn(12'h200, 5'd0, 3'b000, 5'd10, rv_pkg::OP_I));  // Result base
        // R-type ops into x3 from x1 and x2
        emit(r_insn(7'h00, 5'd2, 5'd1, 3'b000, 5'd3));
        store_result(5'd3, A_VAL + B_VAL);
        emit(r_insn(7'h20, 5'd2, 5'd1, 3'b000, 5'd3));
        store_result(5'd3, A_VAL - B_VAL);
        emit(r_insn(7'h00, 5'd2, 5'd1, 3'b111, 5'd3));
        store_result(5'd3, A_VAL & B_VAL);
        emit(r_insn(7'h00, 5'd2, 5'd1, 3'b110, 5'd3));
        store_result(5'd3, A_VAL | B_VAL);
        emit(r_insn(7'h00, 5'd2, 5'd1, 3'b100, 5'd3));
        store_result(5'd3, A_VAL ^ B_VAL);
        emit(r_insn(7'h00, 5'd2, 5'd1, 3'b001, 5'd3));
        store_result(5'd3, A_VAL << B_VAL[4:0]);
        emit(r_insn(7'h00, 5'd2, 5'd1, 3'b101, 5'd3));
        store_result(5'd3, A_VAL >> B_VAL[4:0]);
        emit(r_insn(7'h20, 5'd2, 5'd1, 3'b101, 5'd3));
        store_result(5'd3, $signed(A_VAL) >>> B_VAL[4:0]);  // Sign fill
        // I-type ops into x3 from x1 and imm
        emit(i_insn(12'hFF9, 5'd1, 3'b000, 5'd3, rv_pkg::OP_I));
        store_result(5'd3, A_VAL + 32'hFFFF_FFF9);     // -7
        emit(i_insn(12'hF00, 5'd1, 3'b111, 5'd3, rv_pkg::OP_I));
        store_result(5'd3, A_VAL & 32'hFFFF_FF00);
        emit(i_insn(12'h30A, 5'd1, 3'b110, 5'd3, rv_pkg::OP_I));
        store_result(5'd3, A_VAL | 32'h0000_030A);
        emit(i_insn(12'hFFF, 5'd1, 3'b100, 5'd3, rv_pkg::OP_I));
        store_result(5'd3, ~A_VAL);
        emit(i_insn(12'h004, 5'd1, 3'b001, 5'd3, rv_pkg::OP_I));
        store_result(5'd3, A_VAL << 4);
        emit(i_insn(12'h007, 5'd1, 3'b101, 5'd3, rv_pkg::OP_I));
        store_result(5'd3, A_VAL >> 7);
        emit(i_insn(12'h407, 5'd1, 3'b101, 5'd3, rv_pkg::OP_I));  // SRAI has imm[10] set
        store_result(5'd3, $signed(A_VAL) >>> 7);
        // Round trip through memory
        emit(s_insn(12'h100, 5'd1, 5'd10));
        expect_store(RES_BASE + 32'h100, A_VAL);
        emit(i_insn(12'h100, 5'd10, 3'b010, 5'd4, rv_pkg::OP_LOAD));
        emit(i_insn(12'd99, 5'd4, 3'b000, 5'd4, rv_pkg::OP_I));
        store_result(5'd4, A_VAL + 32'd99);
        emit(i_insn(12'd55, 5'd0, 3'b000, 5'd0, rv_pkg::OP_I));  // x0 stays zero
        store_result(5'd0, 32'd0);
        // ====================
        // Control flow
        // ====================
        emit(i_insn(12'h011, 5'd0, 3'b000, 5'd5, rv_pkg::OP_I));
        jump_from[0] = pc_w;
        jump_to[0]   = pc_w + 32'd8;
        emit(b_insn(13'd8, 5'd5, 5'd5, 3'b000));       // BEQ taken
        emit(s_insn(12'h1F0, 5'd5, 5'd10));            // Marker that must be skipped
        emit(i_insn(12'h022, 5'd0, 3'b000, 5'd7, rv_pkg::OP_I));
        store_result(5'd7, 32'h22);
        emit(b_insn(13'd8, 5'd5, 5'd5, 3'b001));       // BNE falls through
        store_result(5'd5, 32'h11);
        jal_pc       = pc_w;
        jump_from[1] = pc_w;
        jump_to[1]   = pc_w + 32'd8;
        emit(j_insn(21'd8, 5'd8));
        emit(s_insn(12'h1F0, 5'd8, 5'd10));            // Skipped by JAL
        store_result(5'd8, jal_pc + 32'd4);            // Link value
        emit(u_insn(20'hABCDE, 5'd9));
        store_result(5'd9, 32'hABCD_E000);
        end_pc = pc_w;
        emit(j_insn(21'd0, 5'd0));                     // Park here
    endtask

    // ====================
    // Bus memory model
    // ====================
    task automatic watch_protocol;
        assert (wb_cyc || !wb_stb) else abort_run("wb_stb_o is high without wb_cyc_o");
        if (prev_ack) begin
            assert (!wb_stb) else abort_run("wb_stb_o stayed high after the acked cycle");
        end else if (prev_stb) begin                   // Transfer still open
            assert (wb_stb) else abort_run("wb_stb_o dropped before ack");
            assert (wb_adr == prev_adr) else value_mismatch("wb_adr_o", prev_adr, wb_adr);
            assert (wb_we == prev_we) else value_mismatch("wb_we_o", prev_we, wb_we);
            assert (!prev_we || wb_dat_w == prev_dat)
                else value_mismatch("wb_dat_o", prev_dat, wb_dat_w);
        end
    endtask

    task automatic compare_store;
        if (st_idx >= exp_adr.size()) begin
            abort_run("a store came after the last expected one");
        end else begin
            assert (wb_adr == exp_adr[st_idx])
                else value_mismatch("wb_adr_o", exp_adr[st_idx], wb_adr);
            assert (wb_dat_w == exp_dat[st_idx])
                else value_mismatch("wb_dat_o", exp_dat[st_idx], wb_dat_w);
            st_idx++;
        end
    endtask

    task automatic note_fetch;
        for (int j = 0; j < 2; j++) begin
            if (last_fetch == jump_from[j]) begin      // Target of a taken jump
                assert (wb_adr == jump_to[j]) else value_mismatch("wb_adr_o", jump_to[j], wb_adr);
            end
        end
        if (wb_adr == end_pc) begin
            end_hits++;
        end
        last_fetch = wb_adr;
    endtask

    task automatic serve_transfer;
        if (wb_adr[31:10] != '0) begin
            abort_run("bus address lies outside the 1 KiB memory");
        end else if (wb_we) begin
            compare_store();
            mem[wb_adr[9:2]] = wb_dat_w;
        end else begin
            assert (wb_adr[1:0] == 2'b00)
                else value_mismatch("wb_adr_o", {wb_adr[31:2], 2'b00}, wb_adr);
            wb_dat_r = mem[wb_adr[9:2]];
            if (wb_adr < RES_BASE) begin               // Code region reads are fetches
                note_fetch();
            end
        end
    endtask

    always @(posedge clk) begin
        rst_edge_d <= rst_edge;
        rst_edge   <= rst;
    end

    always @(negedge clk) begin
        if (rst_edge !== 1'b0) begin                   // Reset or no rising edge yet
            if (rst_edge === 1'b1) begin
                assert (!wb_cyc && !wb_stb && !wb_we)
                    else value_mismatch("wb_cyc_o/wb_stb_o/wb_we_o", '0,
                                        {wb_cyc, wb_stb, wb_we});
            end
            wb_ack = 1'b0;
        end else begin
            if (rst_edge_d) begin                      // First cycle out of reset
                assert (wb_cyc && wb_stb && !wb_we)
                    else value_mismatch("wb_cyc_o/wb_stb_o/wb_we_o", 3'b110,
                                        {wb_cyc, wb_stb, wb_we});
                assert (wb_adr == RESET_PC) else value_mismatch("wb_adr_o", RESET_PC, wb_adr);
                fetch_seen = 1'b1;
            end
            watch_protocol();
            if (wb_ack) begin
                wb_ack = 1'b0;
                rnd    = $random(seed);
                delay  = rnd[1:0];                     // 0 to 3 wait cycles
            end else if (wb_stb) begin
                if (delay == 2'd0) begin
                    serve_transfer();
                    wb_ack = 1'b1;
                end else begin
                    delay = delay - 2'd1;
                end
            end
        end
        prev_stb = wb_stb;
        prev_ack = wb_ack;
        prev_we  = wb_we;
        prev_adr = wb_adr;
        prev_dat = wb_dat_w;
    end

    // ====================
    // Main sequence
    // ====================
    initial begin
        wb_ack     = 1'b0;
        wb_dat_r   = '0;
        prev_stb   = 1'b0;
        prev_ack   = 1'b0;
        fetch_seen = 1'b0;
        st_idx     = 0;
        end_hits   = 0;
        last_fetch = '1;
        seed       = 32'ha56f_aa6b;
        rnd        = $random(seed);
        delay      = rnd[1:0];
        load_program();

        cnt = 0;
        while (!fetch_seen && cnt < 20) begin
            @(posedge clk);
            cnt++;
        end
        if (!fetch_seen) begin
            abort_run("no fetch request appeared after reset release");
        end

        cnt = 0;
        while (st_idx < exp_adr.size() && cnt < 4000) begin
            @(posedge clk);
            cnt++;
        end
        if (st_idx < exp_adr.size()) begin
            abort_run("timed out waiting for the expected stores");
        end

        cnt = 0;
        while (end_hits < 2 && cnt < 200) begin        // Loop fetched twice
            @(posedge clk);
            cnt++;
        end
        if (end_hits < 2) begin
            abort_run("the final self loop was never reached");
        end

        $display("sim passed");
        $finish;
    end

endmodule : tb_rv_top

//--- sim/tb_clk_gen.sv
`timescale 1ns/100ps

module tb_clk_gen (
    output logic clk_o,
    output logic rst_o
);

    initial begin
        clk_o = 1'b0;
        forever #2 clk_o = ~clk_o;                     // 4 ns period
    end

    initial begin
        rst_o = 1'b1;
        repeat (4) @(posedge clk_o);                   // Four reset edges
        @(negedge clk_o);
        rst_o = 1'b0;                                  // Released on falling edge
    end

endmodule : tb_clk_gen

//--- hdl/rv_top.sv
`timescale 1ns/100ps

module rv_top #(
    parameter rv_pkg::addr_t RESET_PC = '0
) (
    input  logic          clk_i,
    input  logic          rst_i,
    output logic          wb_cyc_o,
    output logic          wb_stb_o,
    output logic          wb_we_o,
    output rv_pkg::addr_t wb_adr_o,
    output rv_pkg::word_t wb_dat_o,
    input  rv_pkg::word_t wb_dat_i,
    input  logic          wb_ack_i
);

    wb_if   wb_bus ();
    ctrl_if ctrl_bus ();

    rv_pkg::word_t insn;
    rv_pkg::word_t imm;
    rv_pkg::word_t rs1_data;
    rv_pkg::word_t rs2_data;
    rv_pkg::word_t alu_b;                              // Operand B after mux
    rv_pkg::word_t alu_y;
    logic          alu_zero;
    logic          rd_wren;
    rv_pkg::word_t rd_data;

    // ====================
    // Bus ports
    // ====================
    assign wb_cyc_o      = wb_bus.cyc;
    assign wb_stb_o      = wb_bus.stb;
    assign wb_we_o       = wb_bus.we;
    assign wb_adr_o      = wb_bus.adr;
    assign wb_dat_o      = wb_bus.dat_w;
    assign wb_bus.dat_r  = wb_dat_i;
    assign wb_bus.ack    = wb_ack_i;

    // ====================
    // Datapath
    // ====================
    control control_i (
        .opcode_i (insn[6:0]),
        .funct3_i (insn[14:12]),
        .funct7_i (insn[31:25]),
        .ctrl     (ctrl_bus.dec)
    );

    imm_gen imm_gen_i (
        .insn_i (insn),
        .fmt_i  (ctrl_bus.imm_fmt),
        .imm_o  (imm)
    );

    reg_file reg_file_i (
        .clk_i    (clk_i),
        .rst_i    (rst_i),
        .rs1_i    (insn[19:15]),
        .rs2_i    (insn[24:20]),
        .rd_i     (insn[11:7]),
        .wren_i   (rd_wren),
        .wdata_i  (rd_data),
        .rdata1_o (rs1_data),
        .rdata2_o (rs2_data)
    );

    assign alu_b = ctrl_bus.imm_sel ? imm : rs2_data;  // Operand A is always rs1

    alu alu_i (
        .a_i    (rs1_data),
        .b_i    (alu_b),
        .op_i   (ctrl_bus.alu_sel),
        .y_o    (alu_y),
        .zero_o (alu_zero)
    );

    bus_sequencer #(
        .RESET_PC (RESET_PC)
    ) bus_sequencer_i (
        .clk_i      (clk_i),
        .rst_i      (rst_i),
        .wb         (wb_bus.master),
        .ctrl       (ctrl_bus.user),
        .insn_o     (insn),
        .pc_o       (),
        .alu_y_i    (alu_y),
        .alu_zero_i (alu_zero),
        .rs2_data_i (rs2_data),
        .imm_i      (imm),
        .rd_wren_o  (rd_wren),
        .rd_data_o  (rd_data)
    );

endmodule : rv_top

//--- hdl/bus_sequencer.sv
`timescale 1ns/100ps

module bus_sequencer #(
    parameter rv_pkg::addr_t RESET_PC = '0
) (
    input  logic          clk_i,
    input  logic          rst_i,
    wb_if.master          wb,
    ctrl_if.user          ctrl,
    output rv_pkg::word_t insn_o,
    output rv_pkg::addr_t pc_o,
    input  rv_pkg::word_t alu_y_i,
    input  logic          alu_zero_i,
    input  rv_pkg::word_t rs2_data_i,
    input  rv_pkg::word_t imm_i,
    output logic          rd_wren_o,
    output rv_pkg::word_t rd_data_o
);

    rv_pkg::seq_state_e state_q;
    rv_pkg::addr_t      pc_q;
    rv_pkg::word_t      insn_q;                        // Instruction register
    rv_pkg::word_t      alu_q;                         // EXEC result
    rv_pkg::word_t      mem_q;                         // Load data
    logic               take_q;                        // Redirect PC in WB
    logic               cyc_q;                         // cyc and stb together
    logic               we_q;
    rv_pkg::addr_t      adr_q;
    rv_pkg::word_t      dat_q;
    logic               take;
    rv_pkg::addr_t      pc_plus4;
    rv_pkg::addr_t      next_pc;

    // ====================
    // Branch resolution
    // ====================
    // insn[12] splits BEQ from BNE
    assign take = ctrl.pc_sel &&
                  ((insn_q[6:0] != rv_pkg::OP_BRANCH) || (insn_q[12] ^ alu_zero_i));
    assign pc_plus4 = pc_q + 32'd4;
    assign next_pc  = take_q ? (pc_q + imm_i) : pc_plus4;  // imm still from insn_q

    // ====================
    // State machine
    // ====================
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state_q <= rv_pkg::S_FETCH;
            pc_q    <= RESET_PC;
            cyc_q   <= 1'b0;
            we_q    <= 1'b0;
            take_q  <= 1'b0;
        end else begin
            case (state_q)
                rv_pkg::S_FETCH: begin
                    if (!cyc_q) begin                  // First fetch after reset
                        cyc_q <= 1'b1;
                        we_q  <= 1'b0;
                        adr_q <= pc_q;
                    end else if (wb.ack) begin
                        insn_q  <= wb.dat_r;
                        cyc_q   <= 1'b0;
                        state_q <= rv_pkg::S_DECODE;
                    end
                end
                rv_pkg::S_DECODE: state_q <= rv_pkg::S_EXEC;  // Regfile read
                rv_pkg::S_EXEC: begin
                    alu_q  <= alu_y_i;
                    take_q <= take;
                    if (ctrl.mem_ren || ctrl.mem_wren) begin
                        cyc_q   <= 1'b1;
                        we_q    <= ctrl.mem_wren;
                        adr_q   <= alu_y_i;            // Effective address
                        dat_q   <= rs2_data_i;
                        state_q <= rv_pkg::S_MEM;
                    end else begin
                        state_q <= rv_pkg::S_WB;
                    end
                end
                rv_pkg::S_MEM: begin
                    if (wb.ack) begin                  // Hold until ack
                        mem_q   <= wb.dat_r;
                        cyc_q   <= 1'b0;
                        we_q    <= 1'b0;
                        state_q <= rv_pkg::S_WB;
                    end
                end
                rv_pkg::S_WB: begin
                    pc_q    <= next_pc;
                    cyc_q   <= 1'b1;                   // Next fetch starts now
                    we_q    <= 1'b0;
                    adr_q   <= next_pc;
                    state_q <= rv_pkg::S_FETCH;
                end
                default: state_q <= rv_pkg::S_FETCH;
            endcase
        end
    end

    // ====================
    // Outputs
    // ====================
    assign wb.cyc   = cyc_q;
    assign wb.stb   = cyc_q;                           // Single transfer per cycle
    assign wb.we    = we_q;
    assign wb.adr   = adr_q;
    assign wb.dat_w = dat_q;

    assign insn_o    = insn_q;
    assign pc_o      = pc_q;
    assign rd_wren_o = (state_q == rv_pkg::S_WB) && ctrl.reg_wren;

    always_comb begin
        case (ctrl.wb_sel)
            rv_pkg::WB_MEM: rd_data_o = mem_q;
            rv_pkg::WB_PC4: rd_data_o = pc_plus4;      // JAL link
            default:        rd_data_o = alu_q;
        endcase
    end

endmodule : bus_sequencer

//--- hdl/reg_file.sv
`timescale 1ns/100ps

module reg_file (
    input  logic             clk_i,
    input  logic             rst_i,
    input  rv_pkg::reg_idx_t rs1_i,
    input  rv_pkg::reg_idx_t rs2_i,
    input  rv_pkg::reg_idx_t rd_i,
    input  logic             wren_i,
    input  rv_pkg::word_t    wdata_i,
    output rv_pkg::word_t    rdata1_o,
    output rv_pkg::word_t    rdata2_o
);

    rv_pkg::word_t regs [1:31];                        // No storage for x0

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wren_i && (rd_i != 5'd0)) begin   // x0 writes dropped
            regs[rd_i] <= wdata_i;
        end
    end

    // Asynchronous read, x0 reads as zero
    assign rdata1_o = (rs1_i == 5'd0) ? '0 : regs[rs1_i];
    assign rdata2_o = (rs2_i == 5'd0) ? '0 : regs[rs2_i];

endmodule : reg_file

//--- hdl/imm_gen.sv
`timescale 1ns/100ps

module imm_gen (
    input  rv_pkg::word_t    insn_i,
    input  rv_pkg::imm_fmt_e fmt_i,
    output rv_pkg::word_t    imm_o
);

    logic sign;                                        // Always insn[31]

    assign sign = insn_i[31];

    always_comb begin
        case (fmt_i)
            rv_pkg::IMM_I: imm_o = {{20{sign}}, insn_i[31:20]};
            rv_pkg::IMM_S: imm_o = {{20{sign}}, insn_i[31:25], insn_i[11:7]};
            rv_pkg::IMM_B: imm_o = {{19{sign}}, sign, insn_i[7], insn_i[30:25],
                                    insn_i[11:8], 1'b0};                 // Even offset
            rv_pkg::IMM_J: imm_o = {{11{sign}}, sign, insn_i[19:12], insn_i[20],
                                    insn_i[30:21], 1'b0};
            rv_pkg::IMM_U: imm_o = {insn_i[31:12], 12'b0};                // Upper 20 bits
            default:       imm_o = '0;
        endcase
    end

endmodule : imm_gen

//--- hdl/alu.sv
`timescale 1ns/100ps

module alu (
    input  rv_pkg::word_t   a_i,
    input  rv_pkg::word_t   b_i,
    input  rv_pkg::alu_op_e op_i,
    output rv_pkg::word_t   y_o,
    output logic            zero_o
);

    logic [4:0] shamt;                                 // Only low 5 bits count

    assign shamt = b_i[4:0];

    always_comb begin
        case (op_i)
            rv_pkg::ALU_ADD:    y_o = a_i + b_i;
            rv_pkg::ALU_SUB:    y_o = a_i - b_i;
            rv_pkg::ALU_AND:    y_o = a_i & b_i;
            rv_pkg::ALU_OR:     y_o = a_i | b_i;
            rv_pkg::ALU_XOR:    y_o = a_i ^ b_i;
            rv_pkg::ALU_SLL:    y_o = a_i << shamt;
            rv_pkg::ALU_SRL:    y_o = a_i >> shamt;
            rv_pkg::ALU_SRA:    y_o = rv_pkg::word_t'($signed(a_i) >>> shamt);  // Sign fill
            rv_pkg::ALU_PASS_B: y_o = b_i;             // LUI
            default:            y_o = '0;
        endcase
    end

    assign zero_o = (y_o == '0);                       // BEQ/BNE compare

endmodule : alu

//--- hdl/control.sv
`timescale 1ns/100ps

module control (
    input  rv_pkg::opcode_t opcode_i,
    input  logic [2:0]      funct3_i,
    input  logic [6:0]      funct7_i,
    ctrl_if.dec             ctrl
);

    always_comb begin
        // Inactive defaults, unknown opcode is a no-op
        ctrl.pc_sel   = 1'b0;
        ctrl.imm_sel  = 1'b0;
        ctrl.reg_wren = 1'b0;
        ctrl.mem_ren  = 1'b0;
        ctrl.mem_wren = 1'b0;
        ctrl.wb_sel   = rv_pkg::WB_ALU;
        ctrl.alu_sel  = rv_pkg::ALU_ADD;
        ctrl.imm_fmt  = rv_pkg::IMM_I;

        case (opcode_i)
            // ====================
            // Register-register
            // ====================
            rv_pkg::OP_R: begin
                ctrl.reg_wren = 1'b1;
                case (funct3_i)
                    3'b000:  ctrl.alu_sel = funct7_i[5] ? rv_pkg::ALU_SUB : rv_pkg::ALU_ADD;
                    3'b111:  ctrl.alu_sel = rv_pkg::ALU_AND;
                    3'b110:  ctrl.alu_sel = rv_pkg::ALU_OR;
                    3'b100:  ctrl.alu_sel = rv_pkg::ALU_XOR;
                    3'b001:  ctrl.alu_sel = rv_pkg::ALU_SLL;
                    3'b101:  ctrl.alu_sel = funct7_i[5] ? rv_pkg::ALU_SRA : rv_pkg::ALU_SRL;
                    default: ctrl.alu_sel = rv_pkg::ALU_ADD;  // Unsupported funct3
                endcase
            end

            // ====================
            // Register-immediate
            // ====================
            rv_pkg::OP_I: begin
                ctrl.reg_wren = 1'b1;
                ctrl.imm_sel  = 1'b1;
                case (funct3_i)
                    3'b000:  ctrl.alu_sel = rv_pkg::ALU_ADD;  // funct7 is imm here
                    3'b111:  ctrl.alu_sel = rv_pkg::ALU_AND;
                    3'b110:  ctrl.alu_sel = rv_pkg::ALU_OR;
                    3'b100:  ctrl.alu_sel = rv_pkg::ALU_XOR;
                    3'b001:  ctrl.alu_sel = rv_pkg::ALU_SLL;
                    3'b101:  ctrl.alu_sel = funct7_i[5] ? rv_pkg::ALU_SRA : rv_pkg::ALU_SRL;
                    default: ctrl.alu_sel = rv_pkg::ALU_ADD;
                endcase
            end

            // ====================
            // Memory
            // ====================
            rv_pkg::OP_LOAD: begin
                ctrl.reg_wren = 1'b1;
                ctrl.imm_sel  = 1'b1;                  // Base + offset
                ctrl.mem_ren  = 1'b1;
                ctrl.wb_sel   = rv_pkg::WB_MEM;
            end

            rv_pkg::OP_STORE: begin
                ctrl.imm_sel  = 1'b1;
                ctrl.mem_wren = 1'b1;                  // Data from rs2
                ctrl.imm_fmt  = rv_pkg::IMM_S;
            end

            // ====================
            // Control flow
            // ====================
            rv_pkg::OP_BRANCH: begin
                ctrl.pc_sel  = 1'b1;                   // Qualified by compare in sequencer
                ctrl.alu_sel = rv_pkg::ALU_SUB;        // rs1 - rs2 for zero test
                ctrl.imm_fmt = rv_pkg::IMM_B;
            end

            rv_pkg::OP_JAL: begin
                ctrl.pc_sel   = 1'b1;
                ctrl.reg_wren = 1'b1;
                ctrl.imm_sel  = 1'b1;
                ctrl.wb_sel   = rv_pkg::WB_PC4;        // Link
                ctrl.imm_fmt  = rv_pkg::IMM_J;
            end

            rv_pkg::OP_LUI: begin
                ctrl.reg_wren = 1'b1;
                ctrl.imm_sel  = 1'b1;
                ctrl.alu_sel  = rv_pkg::ALU_PASS_B;    // rd = imm
                ctrl.imm_fmt  = rv_pkg::IMM_U;
            end

            default: ;                                 // Keep defaults
        endcase
    end

endmodule : control

//--- hdl/ctrl_if.sv
`timescale 1ns/100ps

interface ctrl_if;

    logic               pc_sel;                        // Branch or jump
    logic               imm_sel;                       // ALU operand B from immediate
    logic               reg_wren;                      // Write rd in WB
    logic               mem_ren;                       // Load bus phase
    logic               mem_wren;                      // Store bus phase
    rv_pkg::wb_sel_e    wb_sel;
    rv_pkg::alu_op_e    alu_sel;
    rv_pkg::imm_fmt_e   imm_fmt;

    modport dec (
        output pc_sel, imm_sel, reg_wren, mem_ren, mem_wren, wb_sel, alu_sel, imm_fmt
    );

    // Sequencer, immediate generator and operand mux
    modport user (
        input  pc_sel, imm_sel, reg_wren, mem_ren, mem_wren, wb_sel, alu_sel, imm_fmt
    );

endinterface : ctrl_if

//--- hdl/wb_if.sv
`timescale 1ns/100ps

interface wb_if;

    logic          cyc;                                // Bus cycle in progress
    logic          stb;                                // Transfer request
    logic          we;                                 // 1 = write
    rv_pkg::addr_t adr;
    rv_pkg::word_t dat_w;                              // Master to slave
    rv_pkg::word_t dat_r;                              // Slave to master
    logic          ack;                                // Ends the transfer

    modport master (
        output cyc, stb, we, adr, dat_w,
        input  dat_r, ack
    );

    modport slave (
        input  cyc, stb, we, adr, dat_w,
        output dat_r, ack
    );

endinterface : wb_if

//--- hdl/rv_pkg.sv
package rv_pkg;

    // ====================
    // Data vectors
    // ====================
    typedef logic [31:0] word_t;                       // Register, bus and ALU data
    typedef logic [31:0] addr_t;                       // Byte address on bus and PC
    typedef logic [4:0]  reg_idx_t;                    // x0..x31
    typedef logic [6:0]  opcode_t;                     // insn[6:0]

    // ====================
    // Opcodes
    // ====================
    localparam opcode_t OP_R      = 7'b0110011;        // ADD, SUB, logic, shifts
    localparam opcode_t OP_I      = 7'b0010011;        // ALU with immediate
    localparam opcode_t OP_LOAD   = 7'b0000011;        // LW
    localparam opcode_t OP_STORE  = 7'b0100011;        // SW
    localparam opcode_t OP_BRANCH = 7'b1100011;        // BEQ, BNE
    localparam opcode_t OP_JAL    = 7'b1101111;
    localparam opcode_t OP_LUI    = 7'b0110111;

    // ====================
    // Control encodings
    // ====================
    typedef enum logic [3:0] {
        ALU_ADD    = 4'd0,
        ALU_SUB    = 4'd1,                             // Also the branch compare
        ALU_AND    = 4'd2,
        ALU_OR     = 4'd3,
        ALU_XOR    = 4'd4,
        ALU_SLL    = 4'd5,
        ALU_SRL    = 4'd6,
        ALU_SRA    = 4'd7,
        ALU_PASS_B = 4'd8                              // Operand B straight through
    } alu_op_e;

    typedef enum logic [1:0] {
        WB_ALU = 2'd0,                                 // Latched ALU result
        WB_MEM = 2'd1,                                 // Load data
        WB_PC4 = 2'd2                                  // Link value for JAL
    } wb_sel_e;

    typedef enum logic [2:0] {
        IMM_I,
        IMM_S,
        IMM_B,
        IMM_J,
        IMM_U
    } imm_fmt_e;

    typedef enum logic [2:0] {
        S_FETCH,                                       // Wait for insn ack
        S_DECODE,                                      // Regfile read
        S_EXEC,                                        // ALU, branch decision
        S_MEM,                                         // Load/store bus phase
        S_WB                                           // Rd write, PC update
    } seq_state_e;

endpackage : rv_pkg
